// File: hdl/capture_pkg.sv
package capture_pkg;

    // capture word geometry
    localparam int WORD_W = 16;
    localparam int PAIR_W = 2;             // sig, sig1
    localparam int BYTE_W = 8;             // uart payload

    // pairs packed into one word, oldest pair on top
    localparam logic [3:0] PAIRS_PER_WORD = 4'd8;

    // one packed word, pair = {sig, sig1}
    typedef logic [WORD_W-1:0] sample_word_t;

    // capture and readout sequence
    typedef enum logic [2:0] {
        ST_ARMED,                          // capturing, watching rx
        ST_POST,                           // capturing, counting down
        ST_READ,                           // ram read latency
        ST_SEND_LO,                        // hand low byte to uart
        ST_SEND_HI,                        // hand high byte to uart
        ST_WAIT                            // busy high then low
    } dump_state_t;

endpackage

// File: hdl/sample_packer.sv
module sample_packer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      sig,
    input  logic                      sig1,
    output capture_pkg::sample_word_t word,
    output logic                      word_stb
);

    import capture_pkg::*;

    localparam logic [2:0] LAST_PHASE = 3'(PAIRS_PER_WORD - 1);

    sample_word_t shift;
    sample_word_t next_shift;
    logic [2:0]   phase;
    logic         phase_last;

    // newest pair enters at the bottom
    assign next_shift = {shift[WORD_W-PAIR_W-1:0], sig, sig1};
    assign phase_last = (phase == LAST_PHASE);

    always_ff @(posedge clk) begin
        shift <= next_shift;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            phase    <= '0;
            word_stb <= 1'b0;
        end else begin
            phase    <= phase + 1'b1;              // wraps every eight pairs
            word_stb <= phase_last;
        end
    end

    // eighth pair goes straight into the word
    always_ff @(posedge clk) begin
        if (rst && phase_last) begin
            word <= next_shift;
        end
    end

endmodule

// File: hdl/sample_ram.sv
module sample_ram #(
    parameter int ADDR_W = 8
) (
    input  logic                      clk,
    input  logic                      wr_en,
    input  logic [ADDR_W-1:0]         wr_addr,
    input  capture_pkg::sample_word_t wr_data,
    input  logic [ADDR_W-1:0]         rd_addr,
    output capture_pkg::sample_word_t rd_data
);

    import capture_pkg::*;

    localparam int DEPTH = 2 ** ADDR_W;

    sample_word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, maps onto block ram
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: hdl/dump_ctrl.sv
module dump_ctrl #(
    parameter int ADDR_W     = 8,
    parameter int POST_WORDS = 128
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      rx,
    input  logic                      word_stb,
    input  logic                      busy,
    input  capture_pkg::sample_word_t rd_data,
    output logic                      wr_en,
    output logic [ADDR_W-1:0]         wr_addr,
    output logic [ADDR_W-1:0]         rd_addr,
    output logic [7:0]                tx_byte,
    output logic                      tx_start
);

    import capture_pkg::*;

    localparam logic [ADDR_W-1:0] POST_LAST = ADDR_W'(POST_WORDS - 1);

    dump_state_t       state;
    logic [ADDR_W-1:0] post_cnt;
    logic              hi_next;
    logic              seen_busy;
    logic              load_lo;
    logic              load_hi;

    // capture only while not dumping, strobes during a dump are lost
    assign wr_en = word_stb && (state == ST_ARMED || state == ST_POST);

    assign load_lo = (state == ST_SEND_LO) && !busy;
    assign load_hi = (state == ST_SEND_HI) && !busy;

    // write pointer also marks the freeze point during a dump
    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_addr <= '0;
        end else if (wr_en) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= ST_ARMED;
            post_cnt  <= '0;
            rd_addr   <= '0;
            hi_next   <= 1'b0;
            seen_busy <= 1'b0;
            tx_start  <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (state)
                ST_ARMED: begin
                    if (rx) begin
                        post_cnt <= '0;
                        state    <= ST_POST;
                    end
                end

                ST_POST: begin
                    if (wr_en) begin
                        post_cnt <= post_cnt + 1'b1;
                        if (post_cnt == POST_LAST) begin
                            rd_addr <= wr_addr + 1'b1;     // oldest word
                            state   <= ST_READ;
                        end
                    end
                end

                ST_READ: begin
                    state <= ST_SEND_LO;                   // rd_data valid next
                end

                ST_SEND_LO: begin
                    if (load_lo) begin
                        tx_start <= 1'b1;
                        hi_next  <= 1'b1;
                        state    <= ST_WAIT;
                    end
                end

                ST_SEND_HI: begin
                    if (load_hi) begin
                        tx_start <= 1'b1;
                        hi_next  <= 1'b0;
                        rd_addr  <= rd_addr + 1'b1;
                        state    <= ST_WAIT;
                    end
                end

                ST_WAIT: begin
                    if (busy) begin
                        seen_busy <= 1'b1;
                    end else if (seen_busy) begin
                        seen_busy <= 1'b0;
                        if (hi_next) begin
                            state <= ST_SEND_HI;
                        end else if (rd_addr == wr_addr) begin
                            state <= ST_ARMED;             // full pass done
                        end else begin
                            state <= ST_READ;
                        end
                    end
                end

                default: begin
                    state <= ST_ARMED;
                end
            endcase
        end
    end

    // byte latched at start, ram output may move on afterwards
    always_ff @(posedge clk) begin
        if (load_lo) begin
            tx_byte <= rd_data[BYTE_W-1:0];
        end else if (load_hi) begin
            tx_byte <= rd_data[WORD_W-1:BYTE_W];
        end
    end

endmodule

// File: hdl/uart_tx.sv
module uart_tx #(
    parameter int CLKS_PER_BIT = 40000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    output logic       tx,
    output logic       busy
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [3:0] FRAME_LAST = 4'd9;

    logic [9:0]       frame;
    logic [CNT_W-1:0] baud_cnt;
    logic [3:0]       bit_cnt;
    logic             bit_end;

    assign bit_end = (baud_cnt == BIT_LAST);

    // ones shift in behind the frame, so the line rests high
    assign tx = frame[0];

    always_ff @(posedge clk) begin
        if (!rst) begin
            frame    <= '1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            busy     <= 1'b0;
        end else if (!busy) begin
            if (tx_start) begin
                frame    <= {1'b1, tx_byte, 1'b0};     // stop, data, start
                baud_cnt <= '0;
                bit_cnt  <= '0;
                busy     <= 1'b1;
            end
        end else begin
            if (bit_end) begin
                baud_cnt <= '0;
                frame    <= {1'b1, frame[9:1]};
                if (bit_cnt == FRAME_LAST) begin
                    busy <= 1'b0;                      // stop bit finished
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

endmodule

// File: hdl/hex_dump.sv
module hex_dump #(
    parameter int ADDR_W       = 8,
    parameter int POST_WORDS   = 128,
    parameter int CLKS_PER_BIT = 40000    // 48 MHz, 1200 baud
) (
    input  logic clk,
    input  logic rst,
    input  logic sig,
    input  logic sig1,
    input  logic rx,
    output logic tx
);

    import capture_pkg::*;

    sample_word_t      word;
    logic              word_stb;
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;
    sample_word_t      rd_data;
    logic [7:0]        tx_byte;
    logic              tx_start;
    logic              busy;

    sample_packer i_packer (
        .clk      (clk),
        .rst      (rst),
        .sig      (sig),
        .sig1     (sig1),
        .word     (word),
        .word_stb (word_stb)
    );

    sample_ram #(
        .ADDR_W (ADDR_W)
    ) i_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (word),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    dump_ctrl #(
        .ADDR_W     (ADDR_W),
        .POST_WORDS (POST_WORDS)
    ) i_ctrl (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),             // level trigger only
        .word_stb (word_stb),
        .busy     (busy),
        .rd_data  (rd_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .rd_addr  (rd_addr),
        .tx_byte  (tx_byte),
        .tx_start (tx_start)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx       (tx),
        .busy     (busy)
    );

endmodule

// File: verif/tb_uart_rx.sv
module tb_uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       clk,
    input  logic       line,
    output logic [7:0] data,
    output int         count,
    output int         frame_errs
);

    logic [7:0] shift;

    // line sampled on the falling edge away from dut updates
    initial begin
        data       = '0;
        count      = 0;
        frame_errs = 0;
        shift      = '0;
        forever begin
            @(negedge clk);
            if (line === 1'b0) begin
                repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);     // middle of start bit
                if (line === 1'b0) begin
                    for (int i = 0; i < 8; i++) begin
                        repeat (CLKS_PER_BIT) @(negedge clk);
                        shift[i] = line;                        // lsb first
                    end
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    if (line !== 1'b1) begin
                        frame_errs = frame_errs + 1;
                        $display("framing error: stop bit of byte %0d reads low", count);
                    end
                    // byte is handed on even with a bad stop bit
                    data  = shift;
                    count = count + 1;
                end else begin
                    frame_errs = frame_errs + 1;
                    $display("short low pulse on the tx line between frames");
                end
            end
        end
    end

endmodule

// File: verif/tb_hex_dump.sv
module tb_hex_dump;

    import capture_pkg::*;

    localparam int ADDR_W       = 6;
    localparam int POST_WORDS   = 20;
    localparam int CLKS_PER_BIT = 16;
    localparam int DEPTH        = 2 ** ADDR_W;
    localparam int DUMP_BYTES   = 2 * DEPTH;
    localparam int PPW          = int'(PAIRS_PER_WORD);
    localparam int DUMP_LIMIT   = DUMP_BYTES * 12 * CLKS_PER_BIT + PPW * POST_WORDS + 100;

    logic         clk;
    logic         rst;
    logic         sig;
    logic         sig1;
    logic         rx;
    logic         tx;
    logic         tx_now;
    logic [7:0]   rx_data;
    int           rx_count;
    int           frame_errs;

    logic [31:0]  lfsr;
    int           edge_n;                      // rising edges since reset release
    sample_word_t shift_m;
    sample_word_t model_buf [DEPTH];           // indexed by word number
    sample_word_t exp_q [$];
    logic [7:0]   got_q [$];
    logic         trig_live;
    logic         hung;
    int           trig_edge;
    int           post_cnt;
    int           seen_count;
    int           errors;
    int           test_mark;
    int           tests_ok;
    int           tests_bad;

    hex_dump #(
        .ADDR_W       (ADDR_W),
        .POST_WORDS   (POST_WORDS),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_dut (
        .clk  (clk),
        .rst  (rst),
        .sig  (sig),
        .sig1 (sig1),
        .rx   (rx),
        .tx   (tx)
    );

    tb_uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) i_uart_rx (
        .clk        (clk),
        .line       (tx),
        .data       (rx_data),
        .count      (rx_count),
        .frame_errs (frame_errs)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois lfsr stepped once per bit
    function automatic logic rand_bit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 32'h80200003;
        end
        return lsb;
    endfunction

    function automatic int rand_num(input int width);
        int v;
        v = 0;
        for (int i = 0; i < width; i++) begin
            v = (v << 1) | int'(rand_bit());
        end
        return v;
    endfunction

    task automatic check_word(input string name, input sample_word_t exp, input sample_word_t got);
        if (got !== exp) begin
            errors++;
            $display("Fail %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] got);
        if (got !== exp) begin
            errors++;
            $display("Fail %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic check_line(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            errors++;
            $display("Fail %s: expected %h, got %h", name, exp, got);
        end
    endtask

    // one clock of stimulus, model update and byte pickup
    task automatic step(input logic rx_level);
        logic [ADDR_W-1:0] slot;
        int                freeze;
        int                idx;
        sample_word_t      w;
        @(negedge clk);
        tx_now = tx;
        rst    = 1'b1;                         // first step releases reset
        sig    = rand_bit();
        sig1   = rand_bit();
        rx     = rx_level;
        shift_m = {shift_m[13:0], sig, sig1};  // oldest pair ends on top
        if (edge_n % PPW == PPW - 1) begin
            slot            = ADDR_W'(edge_n / PPW);
            model_buf[slot] = shift_m;
        end
        // strobe of the previous word falls on this edge
        if (trig_live && edge_n % PPW == 0 && edge_n > trig_edge) begin
            post_cnt++;
            if (post_cnt == POST_WORDS) begin
                freeze    = edge_n / PPW - 1;
                trig_live = 1'b0;
                exp_q.delete();
                for (int i = DEPTH - 1; i >= 0; i--) begin
                    slot = ADDR_W'(freeze - i);
                    exp_q.push_back(model_buf[slot]);
                end
            end
        end
        edge_n++;
        @(posedge clk);
        if (rx_count != seen_count) begin
            seen_count = rx_count;
            got_q.push_back(rx_data);
            idx = got_q.size() - 1;
            if (idx < 2 * exp_q.size()) begin
                w = exp_q[idx / 2];
                check_byte("tx byte", (idx % 2) ? w[15:8] : w[7:0], rx_data);
            end
        end
    endtask

    // line must stay high and silent while rx is low
    task automatic idle(input int cycles);
        int start_count;
        start_count = rx_count;
        for (int i = 0; i < cycles; i++) begin
            step(1'b0);
            check_line("tx", 1'b1, tx_now);
        end
        if (rx_count != start_count) begin
            errors++;
            $display("unexpected frame on tx while no dump was running");
        end
    endtask

    task automatic run_dump(input logic noisy);
        int   waited;
        logic pulse;
        got_q.delete();
        trig_edge = edge_n;
        trig_live = 1'b1;
        post_cnt  = 0;
        step(1'b1);
        waited = 0;
        while (got_q.size() < DUMP_BYTES && waited < DUMP_LIMIT) begin
            // stray pulses stop well before the last frame
            pulse = noisy && got_q.size() < DUMP_BYTES - 8 && rand_num(3) == 0;
            step(pulse);
            waited++;
        end
        if (got_q.size() < DUMP_BYTES) begin
            errors++;
            hung = 1'b1;
            $display("timeout: dump stopped after %0d of %0d bytes", got_q.size(), DUMP_BYTES);
        end else if (exp_q.size() != DEPTH) begin
            errors++;
            $display("model never reached the freeze point");
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                check_word($sformatf("dump word %0d", i), exp_q[i], {got_q[2*i+1], got_q[2*i]});
            end
        end
    endtask

    task automatic finish_test(input int num, input string name);
        if (errors == test_mark) begin
            tests_ok++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: failed with %0d errors", num, name, errors - test_mark);
        end
        test_mark = errors;
    endtask

    // a dump that never completes ends the sequence early
    task automatic run_tests();
        idle(200);
        finish_test(1, "idle line after reset");

        idle(PPW * DEPTH + rand_num(6));       // buffer wrapped before trigger
        run_dump(1'b0);
        if (hung) begin
            return;
        end
        idle(400);
        finish_test(2, "first dump");

        idle(PPW * DEPTH + rand_num(5));
        run_dump(1'b1);
        if (hung) begin
            return;
        end
        idle(400);
        finish_test(3, "dump with rx pulses");

        idle(PPW * DEPTH + rand_num(7));
        run_dump(1'b0);
        if (hung) begin
            return;
        end
        idle(400);
        finish_test(4, "dump after resume");

        if (frame_errs != 0) begin
            errors++;
            $display("receiver saw %0d framing errors", frame_errs);
        end
        finish_test(5, "uart framing");
    endtask

    initial begin
        rst        = 1'b0;
        sig        = 1'b0;
        sig1       = 1'b0;
        rx         = 1'b0;
        tx_now     = 1'b1;
        lfsr       = 32'h997d;
        edge_n     = 0;
        shift_m    = '0;
        trig_live  = 1'b0;
        hung       = 1'b0;
        trig_edge  = 0;
        post_cnt   = 0;
        seen_count = 0;
        errors     = 0;
        test_mark  = 0;
        tests_ok   = 0;
        tests_bad  = 0;
        repeat (5) @(posedge clk);

        run_tests();

        $display("%0d tests passed, %0d tests failed, %0d checks failed",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: list.f
hdl/capture_pkg.sv
hdl/sample_packer.sv
hdl/sample_ram.sv
hdl/dump_ctrl.sv
hdl/uart_tx.sv
hdl/hex_dump.sv
verif/tb_uart_rx.sv
verif/tb_hex_dump.sv

// File: run.sh
#!/bin/sh
# compile and run the hex_dump testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_hex_dump -f list.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_hex_dump > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx '\*\* PASS \*\*' "$LOG"; then
    echo "result: pass"
    exit 0
fi

echo "result: fail"
exit 1
